//--- vlog.f
common/forthRegPkg.sv
design/phaseSequencer.sv
design/opxDecoder.sv
registers/registerSequencer.sv
registers/registerFile.sv
design/writeBack.sv
design/registerStage.sv
verif/registerStageTb.sv

//--- run.sh
#!/bin/sh
# compile and run the register stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module registerStageTb \
	--Mdir obj_dir -o registerStageTb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/registerStageTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

exit 0

//--- verif/registerStageTb.sv
`timescale 1ns/1ps

module registerStageTb import forthRegPkg::*; ();

	localparam int dataWidth = 16;
	localparam int ackTimeout = 40;
	localparam int randomCount = 200;

	logic       CLK;
	logic       RESET;
	logic       instrReq;
	instrWordT  instr;
	logic       instrAck;
	readResultT readData;

	// reference registers and the readData expected at the next ack
	logic [dataWidth-1:0] model [8];
	readResultT           expData;

	int handshakeErrors;
	int dataErrors;
	int timeoutErrors;
	int seed;

	registerStage #(.dataWidth(dataWidth)) dut0 (
		.CLK      (CLK),
		.RESET    (RESET),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.readData (readData)
	);

	always #5 CLK = ~CLK;

	// --------------------
	// checks
	// --------------------
	resetAck: assert property (@(posedge CLK) $fell(RESET) |-> !instrAck)
		else begin
			handshakeErrors++;
			$display("** Error at %0t: instrAck = %0b, expected 0", $time, $sampled(instrAck));
		end

	// req rose at edge 0, ack first sampled high at edge 5
	ackRise: assert property (@(posedge CLK) disable iff (RESET)
		$rose(instrAck) |-> ($past(instrReq, 5) && !$past(instrReq, 6)))
		else begin
			handshakeErrors++;
			$display("instrAck rose at the wrong distance from the instrReq edge at %0t", $time);
		end

	ackHold: assert property (@(posedge CLK) disable iff (RESET)
		(instrAck && instrReq) |=> instrAck)
		else begin
			handshakeErrors++;
			$display("** Error at %0t: instrAck = 0, expected 1", $time);
		end

	ackFall: assert property (@(posedge CLK) disable iff (RESET)
		(instrAck && !instrReq) |=> !instrAck)
		else begin
			handshakeErrors++;
			$display("** Error at %0t: instrAck = 1, expected 0", $time);
		end

	// read ports hold the pre-write values while ack is up
	readA: assert property (@(posedge CLK) disable iff (RESET)
		instrAck |-> (readData.a == expData.a))
		else begin
			dataErrors++;
			$display("** Error at %0t: readData.a = %h, expected %h",
				$time, $sampled(readData.a), expData.a);
		end

	readB: assert property (@(posedge CLK) disable iff (RESET)
		instrAck |-> (readData.b == expData.b))
		else begin
			dataErrors++;
			$display("** Error at %0t: readData.b = %h, expected %h",
				$time, $sampled(readData.b), expData.b);
		end

	// --------------------
	// reference model
	// --------------------
	function automatic instrWordT makeInstr(input logic [3:0] seq, input logic byteOp,
		input logic [2:0] idxA, input logic [7:0] operand);
		instrWordT w;
		w.byteOp = byteOp;
		w.seq = seq;
		w.idxA = idxA;
		w.operand.imm = operand;
		return w;
	endfunction

	// undefined codes behave as no-ops
	function automatic regSeqT seqOf(input instrWordT w);
		if (w.seq > 4'd9) begin
			return SEQ_NONE;
		end
		return regSeqT'(w.seq);
	endfunction

	function automatic logic [2:0] idxBOf(input instrWordT w);
		if (seqOf(w) inside {SEQ_LDA_IMM, SEQ_RDA_IMM, SEQ_UPA_IMM}) begin
			return 3'd0;
		end
		return w.operand.regView.idxB;
	endfunction

	function automatic logic readsA(input regSeqT seq);
		return !(seq inside {SEQ_NONE, SEQ_RDB});
	endfunction

	function automatic logic readsB(input regSeqT seq);
		return seq inside {SEQ_RDA_RDB, SEQ_LDA_RDB, SEQ_LDA_UPB, SEQ_RDA_UPB,
			SEQ_UPA_RDB, SEQ_RDB};
	endfunction

	task automatic setExpected(input instrWordT w);
		regSeqT seq;
		seq = seqOf(w);
		expData.a = readsA(seq) ? DATA_WIDTH_MAX'(model[w.idxA]) : '0;
		expData.b = readsB(seq) ? DATA_WIDTH_MAX'(model[idxBOf(w)]) : '0;
	endtask

	// commit of one instruction, B written before A
	task automatic applyModel(input instrWordT w);
		regSeqT               seq;
		logic [2:0]           idxB;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] nextA;
		logic [7:0]           imm;
		seq = seqOf(w);
		idxB = idxBOf(w);
		imm = w.operand.imm;
		a = readsA(seq) ? model[w.idxA] : '0;
		b = readsB(seq) ? model[idxB] : '0;
		case (seq)
			SEQ_LDA_RDB, SEQ_LDA_UPB: nextA = b;
			SEQ_LDA_IMM: nextA = dataWidth'(imm);
			SEQ_UPA_RDB: nextA = a + b;
			SEQ_UPA_IMM: nextA = a + {{(dataWidth-8){imm[7]}}, imm};
			default: nextA = a;
		endcase
		// byte ops touch the low byte only
		if (w.byteOp) begin
			nextA[dataWidth-1:8] = a[dataWidth-1:8];
		end
		if (seq inside {SEQ_LDA_UPB, SEQ_RDA_UPB}) begin
			model[idxB] = b + (w.byteOp ? dataWidth'(1) : dataWidth'(2));
		end
		if (seq inside {SEQ_LDA_RDB, SEQ_LDA_UPB, SEQ_LDA_IMM, SEQ_UPA_RDB, SEQ_UPA_IMM}) begin
			model[w.idxA] = nextA;
		end
	endtask

	// --------------------
	// handshake driver
	// --------------------
	task automatic finishRun();
		$display("errors: handshake %0d, readData %0d, timeout %0d",
			handshakeErrors, dataErrors, timeoutErrors);
		if (handshakeErrors + dataErrors + timeoutErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	task automatic waitAck(input logic level);
		int cycles;
		cycles = 0;
		while (instrAck !== level && cycles < ackTimeout) begin
			@(negedge CLK);
			cycles++;
		end
		if (instrAck !== level) begin
			timeoutErrors++;
			$display("timed out after %0d cycles waiting for instrAck to become %0b",
				cycles, level);
			finishRun();
		end
	endtask

	// called on a falling edge with ack low
	task automatic runInstr(input instrWordT w, input int holdCycles);
		setExpected(w);
		instr = w;
		instrReq = 1'b1;
		waitAck(1'b1);
		applyModel(w);
		// late release of req
		repeat (holdCycles) @(negedge CLK);
		instrReq = 1'b0;
		waitAck(1'b0);
	endtask

	task automatic readAllRegs();
		for (int i = 0; i < 4; i++) begin
			runInstr(makeInstr(SEQ_RDA_RDB, 1'b0, 3'(2 * i), 8'(2 * i + 1)), 0);
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic [31:0] rnd;
		CLK = 1'b0;
		RESET = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		expData = '0;
		handshakeErrors = 0;
		dataErrors = 0;
		timeoutErrors = 0;
		seed = 32'h9bffec44;
		for (int i = 0; i < 8; i++) begin
			model[i] = '0;
		end
		repeat (16) @(negedge CLK);
		RESET = 1'b0;
		@(negedge CLK);

		// everything zero out of reset
		readAllRegs();

		// loads, sign extended adds, register adds
		runInstr(makeInstr(SEQ_LDA_IMM, 1'b0, 3'd1, 8'h85), 0);
		runInstr(makeInstr(SEQ_UPA_IMM, 1'b0, 3'd1, 8'hfe), 2);
		runInstr(makeInstr(SEQ_LDA_IMM, 1'b0, 3'd2, 8'h7f), 1);
		runInstr(makeInstr(SEQ_UPA_IMM, 1'b0, 3'd2, 8'h80), 0);
		runInstr(makeInstr(SEQ_UPA_RDB, 1'b0, 3'd1, 8'd2), 0);
		runInstr(makeInstr(SEQ_LDA_RDB, 1'b0, 3'd3, 8'd1), 3);
		// byte forms keep the upper byte of A
		runInstr(makeInstr(SEQ_LDA_IMM, 1'b1, 3'd2, 8'h12), 0);
		runInstr(makeInstr(SEQ_UPA_IMM, 1'b1, 3'd2, 8'hf0), 0);
		runInstr(makeInstr(SEQ_UPA_RDB, 1'b1, 3'd3, 8'd2), 1);
		runInstr(makeInstr(SEQ_LDA_RDB, 1'b1, 3'd3, 8'd1), 0);
		readAllRegs();

		// pointer steps, word then byte
		runInstr(makeInstr(SEQ_LDA_UPB, 1'b0, 3'd4, 8'd2), 0);
		runInstr(makeInstr(SEQ_LDA_UPB, 1'b1, 3'd5, 8'd2), 2);
		runInstr(makeInstr(SEQ_RDA_UPB, 1'b0, 3'd1, 8'd4), 0);
		runInstr(makeInstr(SEQ_RDA_UPB, 1'b1, 3'd1, 8'd4), 0);
		// same index on both ports, A write wins
		runInstr(makeInstr(SEQ_LDA_IMM, 1'b0, 3'd6, 8'h40), 0);
		runInstr(makeInstr(SEQ_LDA_UPB, 1'b0, 3'd6, 8'd6), 0);
		runInstr(makeInstr(SEQ_RDA_UPB, 1'b1, 3'd6, 8'd6), 0);
		readAllRegs();

		// read only and undefined codes
		runInstr(makeInstr(SEQ_RDB, 1'b0, 3'd1, 8'd2), 0);
		runInstr(makeInstr(SEQ_RDA_IMM, 1'b1, 3'd2, 8'hff), 0);
		runInstr(makeInstr(SEQ_NONE, 1'b0, 3'd3, 8'd4), 1);
		for (int code = 10; code < 16; code++) begin
			runInstr(makeInstr(4'(code), 1'(code), 3'(code), 8'(code + 1)), 0);
		end
		readAllRegs();

		// random instruction run
		for (int i = 0; i < randomCount; i++) begin
			rnd = $random(seed);
			runInstr(instrWordT'(rnd[15:0]), int'(rnd[17:16]));
		end
		readAllRegs();

		finishRun();
	end

endmodule

//--- design/registerStage.sv
`timescale 1ns/1ps

module registerStage import forthRegPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic       CLK,
	input  logic       RESET,
	input  logic       instrReq,
	input  instrWordT  instr,
	output logic       instrAck,
	output readResultT readData
);

	// control path
	phaseT     phase;
	logic      latchInstr;
	decodedOpT op;
	regCtrlT   ctrl;

	// data path
	logic [dataWidth-1:0] rdA;
	logic [dataWidth-1:0] rdB;
	logic [dataWidth-1:0] wrA;
	logic [dataWidth-1:0] wrB;

	// --------------------
	// handshake and phases
	// --------------------
	phaseSequencer phaseSeq0 (
		.CLK        (CLK),
		.RESET      (RESET),
		.instrReq   (instrReq),
		.instrAck   (instrAck),
		.phase      (phase),
		.latchInstr (latchInstr)
	);

	opxDecoder opxDec0 (
		.CLK        (CLK),
		.RESET      (RESET),
		.latchInstr (latchInstr),
		.instr      (instr),
		.op         (op)
	);

	registerSequencer regSeq0 (
		.CLK   (CLK),
		.RESET (RESET),
		.seq   (op.seq),
		.phase (phase),
		.ctrl  (ctrl)
	);

	// --------------------
	// registers and update
	// --------------------
	registerFile #(.dataWidth(dataWidth)) regFile0 (
		.CLK     (CLK),
		.RESET   (RESET),
		.ctrl    (ctrl),
		.execute (phase.execute),
		.idxA    (op.idxA),
		.idxB    (op.idxB),
		.wrA     (wrA),
		.wrB     (wrB),
		.rdA     (rdA),
		.rdB     (rdB)
	);

	writeBack #(.dataWidth(dataWidth)) writeBack0 (
		.op  (op),
		.rdA (rdA),
		.rdB (rdB),
		.wrA (wrA),
		.wrB (wrB)
	);

	// zero extended to the package width
	assign readData.a = DATA_WIDTH_MAX'(rdA);
	assign readData.b = DATA_WIDTH_MAX'(rdB);

endmodule

//--- design/writeBack.sv
`timescale 1ns/1ps

module writeBack import forthRegPkg::*; #(
	parameter int dataWidth = 16
) (
	input  decodedOpT            op,
	input  logic [dataWidth-1:0] rdA,
	input  logic [dataWidth-1:0] rdB,
	output logic [dataWidth-1:0] wrA,
	output logic [dataWidth-1:0] wrB
);

	// immediate forms
	logic [dataWidth-1:0] immZero;
	logic [dataWidth-1:0] immSign;

	// full width result for A before byte merge
	logic [dataWidth-1:0] nextA;

	// pointer step for B
	logic [dataWidth-1:0] step;

	assign immZero = dataWidth'(op.imm);
	assign immSign = {{(dataWidth-8){op.imm[7]}}, op.imm};

	// --------------------
	// register A
	// --------------------
	always_comb begin
		case (op.seq)
			SEQ_LDA_RDB, SEQ_LDA_UPB: nextA = rdB;
			SEQ_LDA_IMM: nextA = immZero;
			SEQ_UPA_RDB: nextA = rdA + rdB;
			// signed offset
			SEQ_UPA_IMM: nextA = rdA + immSign;
			// no write for the others
			default: nextA = rdA;
		endcase
	end

	// byte op only replaces the low byte
	assign wrA = op.byteOp ? {rdA[dataWidth-1:8], nextA[7:0]} : nextA;

	// --------------------
	// register B
	// --------------------
	// one byte or one word per step
	assign step = op.byteOp ? dataWidth'(1) : dataWidth'(2);

	always_comb begin
		case (op.seq)
			SEQ_LDA_UPB, SEQ_RDA_UPB: wrB = rdB + step;
			default: wrB = rdB;
		endcase
	end

endmodule

//--- registers/registerFile.sv
`timescale 1ns/1ps

module registerFile import forthRegPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic                 CLK,
	input  logic                 RESET,
	input  regCtrlT              ctrl,
	input  logic                 execute,
	input  logic [2:0]           idxA,
	input  logic [2:0]           idxB,
	input  logic [dataWidth-1:0] wrA,
	input  logic [dataWidth-1:0] wrB,
	output logic [dataWidth-1:0] rdA,
	output logic [dataWidth-1:0] rdB
);

	// eight general registers
	logic [dataWidth-1:0] regs [8];

	// --------------------
	// read ports
	// --------------------
	// sampled at the end of execute, held until the next one
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rdA <= '0;
			rdB <= '0;
		end else if (execute) begin
			// disabled port reads as zero
			rdA <= ctrl.enA ? regs[idxA] : '0;
			rdB <= ctrl.enB ? regs[idxB] : '0;
		end
	end

	// --------------------
	// write ports
	// --------------------
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// B first
			if (ctrl.wenB) begin
				regs[idxB] <= wrB;
			end
			// A last so it wins on equal indices
			if (ctrl.wenA) begin
				regs[idxA] <= wrA;
			end
		end
	end

endmodule

//--- registers/registerSequencer.sv
`timescale 1ns/1ps

// sequence code to register port controls
//
//          F     D     E     C     A
//  EN   ____________----------------___
//  WEN  ________________________------_
//
// read enables straight from the code
// write enables sampled under commit, one cycle wide
module registerSequencer import forthRegPkg::*; (
	input  logic    CLK,
	input  logic    RESET,
	input  regSeqT  seq,
	input  phaseT   phase,
	output regCtrlT ctrl
);

	// pattern for the current code
	regCtrlT lookup;

	// registered write enables
	logic wenAReg;
	logic wenBReg;

	// --------------------
	// pattern lookup
	// --------------------
	always_comb begin
		case (seq)
			SEQ_NONE: begin
				lookup = '{enA: 1'b0, wenA: 1'b0, enB: 1'b0, wenB: 1'b0};
			end
			SEQ_RDA_RDB: begin
				lookup = '{enA: 1'b1, wenA: 1'b0, enB: 1'b1, wenB: 1'b0};
			end
			SEQ_LDA_RDB: begin
				lookup = '{enA: 1'b1, wenA: 1'b1, enB: 1'b1, wenB: 1'b0};
			end
			SEQ_LDA_UPB: begin
				lookup = '{enA: 1'b1, wenA: 1'b1, enB: 1'b1, wenB: 1'b1};
			end
			SEQ_RDA_UPB: begin
				lookup = '{enA: 1'b1, wenA: 1'b0, enB: 1'b1, wenB: 1'b1};
			end
			SEQ_LDA_IMM: begin
				// A read too, byte loads keep its upper bits
				lookup = '{enA: 1'b1, wenA: 1'b1, enB: 1'b0, wenB: 1'b0};
			end
			SEQ_RDA_IMM: begin
				lookup = '{enA: 1'b1, wenA: 1'b0, enB: 1'b0, wenB: 1'b0};
			end
			SEQ_UPA_RDB: begin
				lookup = '{enA: 1'b1, wenA: 1'b1, enB: 1'b1, wenB: 1'b0};
			end
			SEQ_UPA_IMM: begin
				lookup = '{enA: 1'b1, wenA: 1'b1, enB: 1'b0, wenB: 1'b0};
			end
			SEQ_RDB: begin
				lookup = '{enA: 1'b0, wenA: 1'b0, enB: 1'b1, wenB: 1'b0};
			end
			default: begin
				lookup = '{enA: 1'b0, wenA: 1'b0, enB: 1'b0, wenB: 1'b0};
			end
		endcase
	end

	// --------------------
	// write enable timing
	// --------------------
	// high only in the cycle after commit
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			wenAReg <= 1'b0;
			wenBReg <= 1'b0;
		end else if (phase.commit) begin
			wenAReg <= lookup.wenA;
			wenBReg <= lookup.wenB;
		end else begin
			wenAReg <= 1'b0;
			wenBReg <= 1'b0;
		end
	end

	assign ctrl = '{enA: lookup.enA, wenA: wenAReg, enB: lookup.enB, wenB: wenBReg};

endmodule

//--- design/opxDecoder.sv
`timescale 1ns/1ps

module opxDecoder import forthRegPkg::*; (
	input  logic      CLK,
	input  logic      RESET,
	input  logic      latchInstr,
	input  instrWordT instr,
	output decodedOpT op
);

	// instruction register
	instrWordT instrReg;

	// cleaned up sequence code
	regSeqT seqDec;

	// immediate flavour of sequence
	logic immSeq;

	// --------------------
	// fetch latch
	// --------------------
	// loaded at the end of fetch, held through commit and ack
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instrReg <= '0;
		end else if (latchInstr) begin
			instrReg <= instr;
		end
	end

	// --------------------
	// decode
	// --------------------
	// codes are contiguous from SEQ_NONE up to SEQ_RDB
	always_comb begin
		if (instrReg.seq <= 4'(SEQ_RDB)) begin
			seqDec = regSeqT'(instrReg.seq);
		end else begin
			// undefined code, no register cycle
			seqDec = SEQ_NONE;
		end
	end

	// operand byte carries an immediate for these
	always_comb begin
		case (seqDec)
			SEQ_LDA_IMM, SEQ_RDA_IMM, SEQ_UPA_IMM: immSeq = 1'b1;
			default: immSeq = 1'b0;
		endcase
	end

	always_comb begin
		op.seq    = seqDec;
		op.byteOp = instrReg.byteOp;
		op.idxA   = instrReg.idxA;
		// register view of the operand
		op.idxB   = immSeq ? 3'd0 : instrReg.operand.regView.idxB;
		// immediate view of the same byte
		op.imm    = instrReg.operand.imm;
	end

endmodule

//--- design/phaseSequencer.sv
`timescale 1ns/1ps

// one instruction per handshake
//
//   idle  fetch  decode  exec  commit  ack .. idle
//           latch         read         wen
//                                      instrAck high until req drops
module phaseSequencer import forthRegPkg::*; (
	input  logic  CLK,
	input  logic  RESET,
	input  logic  instrReq,
	output logic  instrAck,
	output phaseT phase,
	output logic  latchInstr
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_COMMIT,
		ST_ACK
	} stateT;

	stateT state;
	stateT nextState;

	// --------------------
	// state register
	// --------------------
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= ST_IDLE;
		end else begin
			state <= nextState;
		end
	end

	// next state
	always_comb begin
		nextState = state;
		case (state)
			ST_IDLE: begin
				// new request only taken with ack low
				if (instrReq) begin
					nextState = ST_FETCH;
				end
			end
			ST_FETCH:   nextState = ST_DECODE;
			ST_DECODE:  nextState = ST_EXECUTE;
			ST_EXECUTE: nextState = ST_COMMIT;
			ST_COMMIT:  nextState = ST_ACK;
			ST_ACK: begin
				// hold ack until environment releases req
				if (!instrReq) begin
					nextState = ST_IDLE;
				end
			end
			default: nextState = ST_IDLE;
		endcase
	end

	// --------------------
	// outputs from state
	// --------------------
	always_comb begin
		phase.fetch   = (state == ST_FETCH);
		phase.decode  = (state == ST_DECODE);
		phase.execute = (state == ST_EXECUTE);
		phase.commit  = (state == ST_COMMIT);
	end

	// word captured on the edge that ends fetch
	assign latchInstr = (state == ST_FETCH);

	// ack rises with the write cycle
	assign instrAck = (state == ST_ACK);

endmodule

//--- common/forthRegPkg.sv
package forthRegPkg;

	// widest register the stage can report on readData
	localparam int DATA_WIDTH_MAX = 32;

	// --------------------
	// register cycle kinds
	// --------------------
	// codes above SEQ_RDB are undefined and run as SEQ_NONE
	typedef enum logic [3:0] {
		SEQ_NONE    = 4'd0,
		SEQ_RDA_RDB = 4'd1,
		SEQ_LDA_RDB = 4'd2,
		SEQ_LDA_UPB = 4'd3,
		SEQ_RDA_UPB = 4'd4,
		SEQ_LDA_IMM = 4'd5,
		SEQ_RDA_IMM = 4'd6,
		SEQ_UPA_RDB = 4'd7,
		SEQ_UPA_IMM = 4'd8,
		SEQ_RDB     = 4'd9
	} regSeqT;

	// --------------------
	// instruction word
	// --------------------
	// register view of the operand byte
	typedef struct packed {
		logic [4:0] unused;
		logic [2:0] idxB;
	} operandRegT;

	// same byte read as a register index or as an immediate
	typedef union packed {
		operandRegT regView;
		logic [7:0] imm;
	} operandU;

	typedef struct packed {
		logic       byteOp;
		logic [3:0] seq;
		logic [2:0] idxA;
		operandU    operand;
	} instrWordT;

	// decoder output seen by the rest of the stage
	typedef struct packed {
		regSeqT     seq;
		logic       byteOp;
		logic [2:0] idxA;
		logic [2:0] idxB;
		logic [7:0] imm;
	} decodedOpT;

	// one-hot phase flags
	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
	} phaseT;

	// register port controls
	typedef struct packed {
		logic enA;
		logic wenA;
		logic enB;
		logic wenB;
	} regCtrlT;

	// read ports widened to the package width
	typedef struct packed {
		logic [DATA_WIDTH_MAX-1:0] a;
		logic [DATA_WIDTH_MAX-1:0] b;
	} readResultT;

endpackage
